// ==== aquila_settings.svh ====
`ifndef AQUILA_SETTINGS_SVH
`define AQUILA_SETTINGS_SVH

// Data and address width
`define AQ_XLEN 32

// TCM geometry in words
`define AQ_TCM_WORDS 1024
`define AQ_TCM_AW 10

// Top address nibble of each local region
`define AQ_SEG_TCM 4'h0
`define AQ_SEG_DEVICE 4'hC
`define AQ_SEG_SYSDEV 4'hF

// System-device select field, nonzero means unmapped
`define AQ_SYSDEV_SEL_HI 19
`define AQ_SYSDEV_SEL_LO 16

// CLINT word offset field inside the system-device window
`define AQ_CLINT_OFS_HI 4
`define AQ_CLINT_OFS_LO 2

// CLINT register word offsets
`define AQ_CLINT_MSIP 3'd0
`define AQ_CLINT_CMP_LO 3'd2
`define AQ_CLINT_CMP_HI 3'd3
`define AQ_CLINT_TIME_LO 3'd4
`define AQ_CLINT_TIME_HI 3'd5

`endif

// ==== aquila_pkg.sv ====
`default_nettype none

`include "aquila_settings.svh"

package aquila_pkg;

    // Region of a data address, picked by the top nibble
    typedef enum logic [1:0] {
        REGION_TCM    = 2'd0,
        REGION_DRAM   = 2'd1,
        REGION_DEVICE = 2'd2,
        REGION_SYSDEV = 2'd3
    } mem_region_e;

    // Owner of the coherence-unit port
    typedef enum logic [1:0] {
        ARB_IDLE   = 2'd0,
        ARB_IFETCH = 2'd1,
        ARB_DATA   = 2'd2
    } arb_state_e;

    // CLINT register map, offsets in words
    typedef enum logic [2:0] {
        CLINT_MSIP    = `AQ_CLINT_MSIP,
        CLINT_CMP_LO  = `AQ_CLINT_CMP_LO,
        CLINT_CMP_HI  = `AQ_CLINT_CMP_HI,
        CLINT_TIME_LO = `AQ_CLINT_TIME_LO,
        CLINT_TIME_HI = `AQ_CLINT_TIME_HI
    } clint_reg_e;

endpackage

`default_nettype wire

// ==== tcm_dp.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "aquila_settings.svh"

module tcm_dp (
    input  wire logic                    clk_i,
    // Instruction port, read only
    input  wire logic                    i_en_i,
    input  wire logic [`AQ_TCM_AW-1:0]   i_addr_i,
    output logic      [`AQ_XLEN-1:0]     i_data_o,
    output logic                         i_ready_o,
    // Data port, read and write
    input  wire logic                    d_en_i,
    input  wire logic                    d_we_i,
    input  wire logic [`AQ_XLEN/8-1:0]   d_be_i,
    input  wire logic [`AQ_TCM_AW-1:0]   d_addr_i,
    input  wire logic [`AQ_XLEN-1:0]     d_wdata_i,
    output logic      [`AQ_XLEN-1:0]     d_rdata_o,
    output logic                         d_ready_o
);

    // Word array shared by both ports
    logic [`AQ_XLEN-1:0] mem [0:`AQ_TCM_WORDS-1];

    // ------------------------------------------------------------
    // Instruction port
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (i_en_i) begin
            i_data_o <= mem[i_addr_i];
        end
        // Code is valid one cycle after the enable
        i_ready_o <= i_en_i;
    end

    // ------------------------------------------------------------
    // Data port
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (d_en_i) begin
            // Read returns the old word on a write
            d_rdata_o <= mem[d_addr_i];
            if (d_we_i) begin
                // Only enabled byte lanes change
                for (int b = 0; b < `AQ_XLEN/8; b++) begin
                    if (d_be_i[b]) begin
                        mem[d_addr_i][8*b +: 8] <= d_wdata_i[8*b +: 8];
                    end
                end
            end
        end
        d_ready_o <= d_en_i;
    end

endmodule

`default_nettype wire

// ==== clint_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "aquila_settings.svh"

module clint_timer
    import aquila_pkg::*;
(
    input  wire logic                 clk_i,
    input  wire logic                 rst_i,
    input  wire logic                 en_i,
    input  wire logic                 we_i,
    input  wire logic [2:0]           addr_i,
    input  wire logic [`AQ_XLEN-1:0]  wdata_i,
    output logic      [`AQ_XLEN-1:0]  rdata_o,
    output logic                      ready_o,
    output logic                      tmr_irq_o,
    output logic                      sft_irq_o
);

    // Free-running time, compare value and software interrupt bit
    logic [63:0]      mtime;
    logic [63:0]      mtimecmp;
    logic             msip;
    clint_reg_e       reg_sel;
    logic [`AQ_XLEN-1:0] rd_word;

    assign reg_sel = clint_reg_e'(addr_i);

    // ------------------------------------------------------------
    // Register writes
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mtime    <= '0;
            // Compare at max keeps the timer interrupt quiet
            mtimecmp <= '1;
            msip     <= 1'b0;
        end else begin
            mtime <= mtime + 64'd1;
            if (en_i && we_i) begin
                case (reg_sel)
                    CLINT_MSIP:    msip           <= wdata_i[0];
                    CLINT_CMP_LO:  mtimecmp[31:0]  <= wdata_i;
                    CLINT_CMP_HI:  mtimecmp[63:32] <= wdata_i;
                    // A written half replaces the incremented one
                    CLINT_TIME_LO: mtime[31:0]     <= wdata_i;
                    CLINT_TIME_HI: mtime[63:32]    <= wdata_i;
                    default: ;
                endcase
            end
        end
    end

    // ------------------------------------------------------------
    // Register reads
    // ------------------------------------------------------------
    always_comb begin
        case (reg_sel)
            CLINT_MSIP:    rd_word = {{(`AQ_XLEN-1){1'b0}}, msip};
            CLINT_CMP_LO:  rd_word = mtimecmp[31:0];
            CLINT_CMP_HI:  rd_word = mtimecmp[63:32];
            CLINT_TIME_LO: rd_word = mtime[31:0];
            CLINT_TIME_HI: rd_word = mtime[63:32];
            // Holes in the map read as zero
            default:       rd_word = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (en_i) begin
            rdata_o <= rd_word;
        end
    end

    // Single-cycle response
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ready_o <= 1'b0;
        end else begin
            ready_o <= en_i;
        end
    end

    // Level interrupts
    assign tmr_irq_o = (mtime >= mtimecmp);
    assign sft_irq_o = msip;

endmodule

`default_nettype wire

// ==== data_port_router.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "aquila_settings.svh"

module data_port_router
    import aquila_pkg::*;
(
    input  wire logic                   clk_i,
    input  wire logic                   rst_i,
    // Data port from the requester
    input  wire logic                   data_strobe_i,
    input  wire logic [`AQ_XLEN-1:0]    data_addr_i,
    input  wire logic                   data_rw_i,
    input  wire logic [`AQ_XLEN/8-1:0]  data_be_i,
    input  wire logic [`AQ_XLEN-1:0]    data_wdata_i,
    output logic      [`AQ_XLEN-1:0]    data_rdata_o,
    output logic                        data_ready_o,
    // TCM data side
    output logic                        tcm_en_o,
    output logic                        tcm_we_o,
    input  wire logic [`AQ_XLEN-1:0]    tcm_rdata_i,
    input  wire logic                   tcm_ready_i,
    // CLINT
    output logic                        clint_en_o,
    output logic                        clint_we_o,
    input  wire logic [`AQ_XLEN-1:0]    clint_rdata_i,
    input  wire logic                   clint_ready_i,
    // Uncached device port
    output logic                        dev_strobe_o,
    output logic      [`AQ_XLEN-1:0]    dev_addr_o,
    output logic                        dev_rw_o,
    output logic      [`AQ_XLEN/8-1:0]  dev_be_o,
    output logic      [`AQ_XLEN-1:0]    dev_wdata_o,
    input  wire logic [`AQ_XLEN-1:0]    dev_rdata_i,
    input  wire logic                   dev_ready_i
);

    mem_region_e region;
    mem_region_e region_r;
    logic        sysdev_unmapped;
    logic        unmapped_r;
    logic        fake_ready_r;
    logic        dev_sel;

    // ------------------------------------------------------------
    // Address decode
    // ------------------------------------------------------------
    always_comb begin
        case (data_addr_i[`AQ_XLEN-1 -: 4])
            `AQ_SEG_TCM:    region = REGION_TCM;
            `AQ_SEG_DEVICE: region = REGION_DEVICE;
            `AQ_SEG_SYSDEV: region = REGION_SYSDEV;
            // Cached DRAM and any other nibble
            default:        region = REGION_DRAM;
        endcase
    end

    // Only select value zero maps to the CLINT
    assign sysdev_unmapped = |data_addr_i[`AQ_SYSDEV_SEL_HI:`AQ_SYSDEV_SEL_LO];
    assign dev_sel         = (region == REGION_DEVICE);

    // Target strobes
    assign tcm_en_o   = data_strobe_i && (region == REGION_TCM);
    assign tcm_we_o   = data_rw_i && (region == REGION_TCM);
    assign clint_en_o = data_strobe_i && (region == REGION_SYSDEV) && !sysdev_unmapped;
    assign clint_we_o = data_rw_i && (region == REGION_SYSDEV) && !sysdev_unmapped;

    // Device port sees zeros unless it is addressed
    assign dev_strobe_o = data_strobe_i && dev_sel;
    assign dev_addr_o   = dev_sel ? data_addr_i : '0;
    assign dev_rw_o     = data_rw_i && dev_sel;
    assign dev_be_o     = data_be_i;
    assign dev_wdata_o  = dev_sel ? data_wdata_i : '0;

    // ------------------------------------------------------------
    // Response select, one cycle behind the request
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            // DRAM never answers, so ready stays low out of reset
            region_r     <= REGION_DRAM;
            unmapped_r   <= 1'b0;
            fake_ready_r <= 1'b0;
        end else begin
            region_r     <= region;
            unmapped_r   <= sysdev_unmapped;
            // Unmapped system devices answer by themselves
            fake_ready_r <= data_strobe_i && (region == REGION_SYSDEV) && sysdev_unmapped;
        end
    end

    always_comb begin
        case (region_r)
            REGION_TCM: begin
                data_rdata_o = tcm_rdata_i;
                data_ready_o = tcm_ready_i;
            end
            REGION_DEVICE: begin
                data_rdata_o = dev_rdata_i;
                data_ready_o = dev_ready_i;
            end
            REGION_SYSDEV: begin
                data_rdata_o = unmapped_r ? '0 : clint_rdata_i;
                data_ready_o = unmapped_r ? fake_ready_r : clint_ready_i;
            end
            default: begin
                data_rdata_o = '0;
                data_ready_o = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== refill_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "aquila_settings.svh"

module refill_arbiter
    import aquila_pkg::*;
(
    input  wire logic                 clk_i,
    input  wire logic                 rst_i,
    // Instruction-side refill
    input  wire logic                 irefill_strobe_i,
    input  wire logic [`AQ_XLEN-1:0]  irefill_addr_i,
    output logic                      irefill_ready_o,
    // Data-side refill
    input  wire logic                 drefill_strobe_i,
    input  wire logic [`AQ_XLEN-1:0]  drefill_addr_i,
    input  wire logic                 drefill_rw_i,
    output logic                      drefill_ready_o,
    // Coherence-unit port
    output logic                      cu_strobe_o,
    output logic      [`AQ_XLEN-1:0]  cu_addr_o,
    output logic                      cu_rw_o,
    output logic                      cu_is_ifetch_o,
    input  wire logic                 cu_ready_i
);

    arb_state_e state;
    arb_state_e state_nxt;

    // ------------------------------------------------------------
    // Grant FSM
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state <= ARB_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ARB_IDLE: begin
                // Instruction side wins a tie
                if (irefill_strobe_i) begin
                    state_nxt = ARB_IFETCH;
                end else if (drefill_strobe_i) begin
                    state_nxt = ARB_DATA;
                end
            end
            ARB_IFETCH, ARB_DATA: begin
                if (cu_ready_i) begin
                    state_nxt = ARB_IDLE;
                end
            end
            default: state_nxt = ARB_IDLE;
        endcase
    end

    // ------------------------------------------------------------
    // Request outputs, registered from the next state
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i || state_nxt == ARB_IDLE) begin
            cu_strobe_o    <= 1'b0;
            cu_addr_o      <= '0;
            cu_rw_o        <= 1'b0;
            cu_is_ifetch_o <= 1'b0;
        end else if (state_nxt == ARB_IFETCH) begin
            cu_strobe_o    <= 1'b1;
            cu_addr_o      <= irefill_addr_i;
            cu_rw_o        <= 1'b0;
            cu_is_ifetch_o <= 1'b1;
        end else begin
            cu_strobe_o    <= 1'b1;
            cu_addr_o      <= drefill_addr_i;
            cu_rw_o        <= drefill_rw_i;
            cu_is_ifetch_o <= 1'b0;
        end
    end

    // Ready goes back to the current owner only
    assign irefill_ready_o = (state == ARB_IFETCH) && cu_ready_i;
    assign drefill_ready_o = (state == ARB_DATA) && cu_ready_i;

endmodule

`default_nettype wire

// ==== aquila_mem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "aquila_settings.svh"

module aquila_mem_top
    import aquila_pkg::*;
(
    input  wire logic                   clk_i,
    input  wire logic                   rst_i,
    // Instruction fetch port
    input  wire logic                   inst_strobe_i,
    input  wire logic [`AQ_XLEN-1:0]    inst_addr_i,
    output logic      [`AQ_XLEN-1:0]    inst_code_o,
    output logic                        inst_ready_o,
    // Data port
    input  wire logic                   data_strobe_i,
    input  wire logic [`AQ_XLEN-1:0]    data_addr_i,
    input  wire logic                   data_rw_i,
    input  wire logic [`AQ_XLEN/8-1:0]  data_be_i,
    input  wire logic [`AQ_XLEN-1:0]    data_wdata_i,
    output logic      [`AQ_XLEN-1:0]    data_rdata_o,
    output logic                        data_ready_o,
    // Uncached device port
    output logic                        dev_strobe_o,
    output logic      [`AQ_XLEN-1:0]    dev_addr_o,
    output logic                        dev_rw_o,
    output logic      [`AQ_XLEN/8-1:0]  dev_be_o,
    output logic      [`AQ_XLEN-1:0]    dev_wdata_o,
    input  wire logic [`AQ_XLEN-1:0]    dev_rdata_i,
    input  wire logic                   dev_ready_i,
    // Interrupts
    output logic                        tmr_irq_o,
    output logic                        sft_irq_o,
    // Refill requests
    input  wire logic                   irefill_strobe_i,
    input  wire logic [`AQ_XLEN-1:0]    irefill_addr_i,
    output logic                        irefill_ready_o,
    input  wire logic                   drefill_strobe_i,
    input  wire logic [`AQ_XLEN-1:0]    drefill_addr_i,
    input  wire logic                   drefill_rw_i,
    output logic                        drefill_ready_o,
    // Coherence-unit port
    output logic                        cu_strobe_o,
    output logic      [`AQ_XLEN-1:0]    cu_addr_o,
    output logic                        cu_rw_o,
    output logic                        cu_is_ifetch_o,
    input  wire logic                   cu_ready_i
);

    mem_region_e         inst_region;
    logic                tcm_i_en;
    logic                tcm_d_en;
    logic                tcm_d_we;
    logic [`AQ_XLEN-1:0] tcm_d_rdata;
    logic                tcm_d_ready;
    logic                clint_en;
    logic                clint_we;
    logic [`AQ_XLEN-1:0] clint_rdata;
    logic                clint_ready;

    // ------------------------------------------------------------
    // Fetches outside the TCM are left unanswered
    // ------------------------------------------------------------
    assign inst_region = (inst_addr_i[`AQ_XLEN-1 -: 4] == `AQ_SEG_TCM) ? REGION_TCM
                                                                       : REGION_DRAM;
    assign tcm_i_en    = inst_strobe_i && (inst_region == REGION_TCM);

    data_port_router u_router (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .data_strobe_i (data_strobe_i),
        .data_addr_i   (data_addr_i),
        .data_rw_i     (data_rw_i),
        .data_be_i     (data_be_i),
        .data_wdata_i  (data_wdata_i),
        .data_rdata_o  (data_rdata_o),
        .data_ready_o  (data_ready_o),
        .tcm_en_o      (tcm_d_en),
        .tcm_we_o      (tcm_d_we),
        .tcm_rdata_i   (tcm_d_rdata),
        .tcm_ready_i   (tcm_d_ready),
        .clint_en_o    (clint_en),
        .clint_we_o    (clint_we),
        .clint_rdata_i (clint_rdata),
        .clint_ready_i (clint_ready),
        .dev_strobe_o  (dev_strobe_o),
        .dev_addr_o    (dev_addr_o),
        .dev_rw_o      (dev_rw_o),
        .dev_be_o      (dev_be_o),
        .dev_wdata_o   (dev_wdata_o),
        .dev_rdata_i   (dev_rdata_i),
        .dev_ready_i   (dev_ready_i)
    );

    // Both ports index the TCM by word
    tcm_dp u_tcm (
        .clk_i     (clk_i),
        .i_en_i    (tcm_i_en),
        .i_addr_i  (inst_addr_i[`AQ_TCM_AW+1:2]),
        .i_data_o  (inst_code_o),
        .i_ready_o (inst_ready_o),
        .d_en_i    (tcm_d_en),
        .d_we_i    (tcm_d_we),
        .d_be_i    (data_be_i),
        .d_addr_i  (data_addr_i[`AQ_TCM_AW+1:2]),
        .d_wdata_i (data_wdata_i),
        .d_rdata_o (tcm_d_rdata),
        .d_ready_o (tcm_d_ready)
    );

    clint_timer u_clint (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .en_i      (clint_en),
        .we_i      (clint_we),
        .addr_i    (data_addr_i[`AQ_CLINT_OFS_HI:`AQ_CLINT_OFS_LO]),
        .wdata_i   (data_wdata_i),
        .rdata_o   (clint_rdata),
        .ready_o   (clint_ready),
        .tmr_irq_o (tmr_irq_o),
        .sft_irq_o (sft_irq_o)
    );

    refill_arbiter u_arbiter (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .irefill_strobe_i (irefill_strobe_i),
        .irefill_addr_i   (irefill_addr_i),
        .irefill_ready_o  (irefill_ready_o),
        .drefill_strobe_i (drefill_strobe_i),
        .drefill_addr_i   (drefill_addr_i),
        .drefill_rw_i     (drefill_rw_i),
        .drefill_ready_o  (drefill_ready_o),
        .cu_strobe_o      (cu_strobe_o),
        .cu_addr_o        (cu_addr_o),
        .cu_rw_o          (cu_rw_o),
        .cu_is_ifetch_o   (cu_is_ifetch_o),
        .cu_ready_i       (cu_ready_i)
    );

endmodule

`default_nettype wire

// ==== tb_aquila_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "aquila_settings.svh"

module tb_aquila_mem
    import aquila_pkg::*;
;
    logic clk_i, rst_i;
    logic inst_strobe_i, data_strobe_i, data_rw_i, dev_ready_i;
    logic [31:0] inst_addr_i, data_addr_i, data_wdata_i, dev_rdata_i;
    logic [3:0] data_be_i;
    logic irefill_strobe_i, drefill_strobe_i, drefill_rw_i, cu_ready_i;
    logic [31:0] irefill_addr_i, drefill_addr_i;
    wire logic [31:0] inst_code_o, data_rdata_o, dev_addr_o, dev_wdata_o, cu_addr_o;
    wire logic inst_ready_o, data_ready_o, dev_strobe_o, dev_rw_o, tmr_irq_o, sft_irq_o;
    wire logic [3:0] dev_be_o;
    wire logic irefill_ready_o, drefill_ready_o, cu_strobe_o, cu_rw_o, cu_is_ifetch_o;

    int seed = 18135;
    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int test_start;
    // TCM shadow model and the stored device word
    logic [31:0] shadow [0:`AQ_TCM_WORDS-1];
    logic [31:0] dev_word;
    logic [31:0] rd;
    logic [31:0] t0;
    logic [31:0] t1;
    int lat;

    aquila_mem_top DUT (.*);

    always #4 clk_i = ~clk_i;

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors != test_start) tests_failed++;
        $display("Test %0d %s: %s", tests_run, name, (errors == test_start) ? "ok" : "failed");
        test_start = errors;
    endtask

    // Word address of a CLINT register with the select field at zero
    function automatic logic [31:0] clint_addr(input clint_reg_e r);
        return {`AQ_SEG_SYSDEV, 23'h0, r, 2'b00};
    endfunction

    // Starts on a falling edge and returns on the falling edge that shows ready
    task automatic data_access(input logic [31:0] addr, input logic rw, input logic [3:0] be,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output int cycles);
        data_strobe_i = 1'b1;
        data_addr_i   = addr;
        data_rw_i     = rw;
        data_be_i     = be;
        data_wdata_i  = wdata;
        #1;
        // Only the device region may reach the device port
        if (addr[31:28] != `AQ_SEG_DEVICE) check_value("dev_strobe_o", dev_strobe_o, 0);
        @(negedge clk_i);
        data_strobe_i = 1'b0;
        cycles = 1;
        while (!data_ready_o && cycles < 20) begin
            @(negedge clk_i);
            cycles++;
        end
        assert (data_ready_o) else begin
            $display("Data port gave no ready within 20 cycles at address %h", addr);
            errors++;
        end
        rdata = data_rdata_o;
    endtask

    // Device responder answers after a delay of 1 to 4 cycles
    task automatic device_access(input logic [31:0] addr, input logic rw, input logic [3:0] be,
                                 input logic [31:0] wdata, input int delay);
        data_strobe_i = 1'b1;
        data_addr_i   = addr;
        data_rw_i     = rw;
        data_be_i     = be;
        data_wdata_i  = wdata;
        #1;
        // Request passes straight through to the device
        check_value("dev_strobe_o", dev_strobe_o, 1);
        check_value("dev_addr_o", dev_addr_o, addr);
        check_value("dev_rw_o", dev_rw_o, rw);
        check_value("dev_be_o", dev_be_o, be);
        check_value("dev_wdata_o", dev_wdata_o, wdata);
        if (rw) dev_word = wdata;
        @(negedge clk_i);
        data_strobe_i = 1'b0;
        // No ready while the device is still busy
        for (int k = 1; k < delay; k++) begin
            check_value("data_ready_o", data_ready_o, 0);
            @(negedge clk_i);
        end
        dev_ready_i = 1'b1;
        dev_rdata_i = dev_word;
        #1;
        check_value("data_ready_o", data_ready_o, 1);
        if (!rw) check_value("data_rdata_o", data_rdata_o, dev_word);
        @(negedge clk_i);
        dev_ready_i = 1'b0;
        dev_rdata_i = $random(seed);
    endtask

    // Instruction fetch from TCM with ready expected one cycle later
    task automatic fetch(input logic [31:0] addr, output logic [31:0] code, output int cycles);
        inst_strobe_i = 1'b1;
        inst_addr_i   = addr;
        @(negedge clk_i);
        inst_strobe_i = 1'b0;
        cycles = 1;
        while (!inst_ready_o && cycles < 20) begin
            @(negedge clk_i);
            cycles++;
        end
        assert (inst_ready_o) else begin
            $display("Instruction port gave no ready at address %h", addr);
            errors++;
        end
        code = inst_code_o;
    endtask

    // One round of concurrent refill requests with a random CU delay
    task automatic refill_round();
        logic pend_i, pend_d, own_i;
        int delay, wait_cnt, guard;
        pend_i = 1'($random(seed));
        pend_d = 1'($random(seed));
        if (!pend_i && !pend_d) pend_d = 1'b1;
        irefill_strobe_i = pend_i;
        drefill_strobe_i = pend_d;
        irefill_addr_i   = $random(seed);
        drefill_addr_i   = $random(seed);
        drefill_rw_i     = 1'($random(seed));
        delay    = $unsigned($random(seed)) % 4;
        wait_cnt = 0;
        guard    = 0;
        while ((pend_i || pend_d) && guard < 200) begin
            @(negedge clk_i);
            guard++;
            cu_ready_i = 1'b0;
            if (cu_strobe_o) begin
                // Instruction side is served first when both wait
                own_i = pend_i;
                check_value("cu_is_ifetch_o", cu_is_ifetch_o, own_i);
                check_value("cu_addr_o", cu_addr_o, own_i ? irefill_addr_i : drefill_addr_i);
                if (!own_i) check_value("cu_rw_o", cu_rw_o, drefill_rw_i);
                if (wait_cnt >= delay) begin
                    cu_ready_i = 1'b1;
                    #1;
                    // Ready reaches the owner only
                    check_value("irefill_ready_o", irefill_ready_o, own_i);
                    check_value("drefill_ready_o", drefill_ready_o, !own_i);
                    if (own_i) begin
                        pend_i = 1'b0;
                        irefill_strobe_i = 1'b0;
                    end else begin
                        pend_d = 1'b0;
                        drefill_strobe_i = 1'b0;
                    end
                    wait_cnt = 0;
                    delay = $unsigned($random(seed)) % 4;
                end else begin
                    wait_cnt++;
                end
            end
            if (!cu_ready_i) begin
                #1;
                check_value("irefill_ready_o", irefill_ready_o, 0);
                check_value("drefill_ready_o", drefill_ready_o, 0);
            end
        end
        assert (!pend_i && !pend_d) else begin
            $display("Refill request was not answered within 200 cycles");
            errors++;
        end
        @(negedge clk_i);
        cu_ready_i = 1'b0;
    endtask

    initial begin
        logic [9:0] idx [0:15];
        logic [31:0] wd;
        logic [3:0] be;
        int guard;
        clk_i = 1'b0;
        rst_i = 1'b1;
        {inst_strobe_i, data_strobe_i, data_rw_i, dev_ready_i} = '0;
        {inst_addr_i, data_addr_i, data_wdata_i, dev_rdata_i} = '0;
        data_be_i = '0;
        {irefill_strobe_i, drefill_strobe_i, drefill_rw_i, cu_ready_i} = '0;
        irefill_addr_i = '0;
        drefill_addr_i = '0;
        dev_word = 32'h5a5a_0001;
        repeat (10) @(negedge clk_i);
        rst_i = 1'b0;
        test_start = 0;
        check_value("cu_strobe_o", cu_strobe_o, 0);
        check_value("data_ready_o", data_ready_o, 0);
        check_value("inst_ready_o", inst_ready_o, 0);
        check_value("tmr_irq_o", tmr_irq_o, 0);
        check_value("sft_irq_o", sft_irq_o, 0);
        finish_test("reset state");

        // ------------------------------------------------------------
        // TCM through both ports
        // ------------------------------------------------------------
        // One word per 61-word slot keeps the indexes distinct
        for (int i = 0; i < 16; i++) begin
            idx[i] = 10'(i * 61 + ($unsigned($random(seed)) % 61));
            wd = $random(seed);
            shadow[idx[i]] = wd;
            data_access({20'h0, idx[i], 2'b00}, 1'b1, 4'hf, wd, rd, lat);
        end
        // Partial writes through random byte lanes
        for (int i = 0; i < 32; i++) begin
            wd = $random(seed);
            be = 4'($random(seed));
            for (int b = 0; b < 4; b++)
                if (be[b]) shadow[idx[i % 16]][8*b +: 8] = wd[8*b +: 8];
            data_access({20'h0, idx[i % 16], 2'b00}, 1'b1, be, wd, rd, lat);
            check_value("write latency", lat, 1);
        end
        for (int i = 0; i < 16; i++) begin
            data_access({20'h0, idx[i], 2'b00}, 1'b0, 4'hf, 0, rd, lat);
            check_value("data_rdata_o", rd, shadow[idx[i]]);
            check_value("data latency", lat, 1);
            fetch({20'h0, idx[i], 2'b00}, rd, lat);
            check_value("inst_code_o", rd, shadow[idx[i]]);
            check_value("fetch latency", lat, 1);
        end
        finish_test("TCM random access");

        for (int i = 0; i < 8; i++) begin
            device_access({4'hC, 28'($random(seed)) & 28'hffffffc}, 1'b1, 4'($random(seed)),
                          $random(seed), 1 + $unsigned($random(seed)) % 4);
            device_access({4'hC, 28'($random(seed)) & 28'hffffffc}, 1'b0, 4'hf,
                          0, 1 + $unsigned($random(seed)) % 4);
        end
        finish_test("device port");

        data_access(32'hF003_0008, 1'b0, 4'hf, 0, rd, lat);
        check_value("data_rdata_o", rd, 0);
        check_value("unmapped latency", lat, 1);
        finish_test("unmapped system device");

        // ------------------------------------------------------------
        // CLINT
        // ------------------------------------------------------------
        data_access(clint_addr(CLINT_MSIP), 1'b1, 4'hf, 1, rd, lat);
        check_value("sft_irq_o", sft_irq_o, 1);
        data_access(clint_addr(CLINT_MSIP), 1'b1, 4'hf, 0, rd, lat);
        check_value("sft_irq_o", sft_irq_o, 0);
        data_access(clint_addr(CLINT_TIME_LO), 1'b0, 4'hf, 0, t0, lat);
        data_access(clint_addr(CLINT_TIME_LO), 1'b0, 4'hf, 0, t1, lat);
        assert (t1 > t0) else begin
            $display("Time did not increase between reads: %h then %h", t0, t1);
            errors++;
        end
        // Compare lands a few dozen cycles ahead of the time just read
        data_access(clint_addr(CLINT_TIME_HI), 1'b0, 4'hf, 0, rd, lat);
        data_access(clint_addr(CLINT_CMP_LO), 1'b1, 4'hf, t1 + 40, wd, lat);
        data_access(clint_addr(CLINT_CMP_HI), 1'b1, 4'hf, rd, wd, lat);
        check_value("tmr_irq_o", tmr_irq_o, 0);
        guard = 0;
        while (!tmr_irq_o && guard < 100) begin
            @(negedge clk_i);
            guard++;
        end
        assert (tmr_irq_o) else begin
            $display("Timer interrupt did not rise within 100 cycles");
            errors++;
        end
        finish_test("CLINT");

        for (int r = 0; r < 40; r++) refill_round();
        finish_test("refill arbitration");

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+.
aquila_pkg.sv
tcm_dp.sv
clint_timer.sv
data_port_router.sv
refill_arbiter.sv
aquila_mem_top.sv
tb_aquila_mem.sv

// ==== Bender.yml ====
package:
  name: aquila_mem

export_include_dirs:
  - .

sources:
  - aquila_pkg.sv
  - tcm_dp.sv
  - clint_timer.sv
  - data_port_router.sv
  - refill_arbiter.sv
  - aquila_mem_top.sv
  - target: test
    files:
      - tb_aquila_mem.sv
